// ==== comp_volt_pkg.sv ====
// ==============================
// Comparator voltage-code package
// Unsigned voltage codes, 1 LSB = 20 mV / 256
// Supply, common mode, rails and preamp constants
// ==============================

package comp_volt_pkg;

    // ==============================
    // Code types
    // ==============================

    typedef logic [15:0] volt_t;         // Single-ended level code
    typedef logic signed [17:0] vdiff_t; // Signed differential value

    // ==============================
    // Analog scaling
    // ==============================

    // 2.8 V analog supply
    localparam volt_t VDDA_CODE = 16'd35840;

    // Mid-supply, also the latch reset level
    localparam volt_t VCM_CODE = VDDA_CODE / 2;

    // Preamp output swing limits, 0.2 V inside each rail
    localparam volt_t RAIL_LO_CODE = 16'd2560;
    localparam volt_t RAIL_HI_CODE = 2 * VCM_CODE - RAIL_LO_CODE;

    // ==============================
    // Preamp model
    // ==============================

    // Input-referred offset, roughly 0.8 mV
    localparam volt_t PREAMP_OFFSET_CODE = 16'd10;

    // Gain of 32 as a left shift
    localparam int PREAMP_GAIN_SHIFT = 5;

endpackage : comp_volt_pkg

// ==== comp_latch_pkg.sv ====
// ==============================
// Comparator latch package
// Calibration code types, trim scaling and
// regenerative latch decision constants
// ==============================

package comp_latch_pkg;

    // ==============================
    // Calibration codes
    // ==============================

    typedef logic [7:0] cal_code_t;  // Offset trim code
    typedef logic [3:0] hyst_code_t; // Hysteresis code

    // Offset code for zero trim
    localparam cal_code_t CAL_MID_CODE = 8'd128;

    // One hysteresis step in voltage LSBs
    localparam int HYST_STEP_CODE = 8;

    // ==============================
    // Regeneration
    // ==============================

    typedef logic signed [19:0] regen_t; // Integrator state

    // Step size as right shift of latch input
    localparam int REGEN_SHIFT = 4;

    // Decision level, either polarity
    localparam regen_t REGEN_THRESHOLD = 20'sd2048;

    // Integrator saturation, symmetric
    localparam regen_t REGEN_MAX = 20'sd262143;
    localparam regen_t REGEN_MIN = -REGEN_MAX;

endpackage : comp_latch_pkg

// ==== comp_phase_ctrl.sv ====
// ==============================
// Comparator phase control
// Two-stage latch/reset phase pipeline
// and the registered ready flag
// ==============================

module comp_phase_ctrl (
    input  logic clk_i,
    input  logic reset_n_i,
    input  logic enable_i,
    input  logic latch_enable_i,
    input  logic reset_latch_i,
    output logic latch_phase_d_o,  // Latch phase, 2 cycles after request
    output logic reset_phase_d_o,  // Reset phase, 2 cycles after request
    output logic ready_o
);

    logic latch_phase; // First stage
    logic reset_phase;

    // Decode requests, mutually exclusive
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            latch_phase <= 1'b0;
            reset_phase <= 1'b1;  // Power up in reset phase
        end else begin
            latch_phase <= latch_enable_i && !reset_latch_i;
            reset_phase <= reset_latch_i && !latch_enable_i;
        end
    end

    // Second stage, drives the latch
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            latch_phase_d_o <= 1'b0;
            reset_phase_d_o <= 1'b1;
            ready_o         <= 1'b0;
        end else begin
            latch_phase_d_o <= latch_phase;
            reset_phase_d_o <= reset_phase;
            ready_o         <= enable_i && !latch_phase_d_o; // Idle and enabled
        end
    end

endmodule : comp_phase_ctrl

// ==== comp_cal_trim.sv ====
// ==============================
// Comparator calibration trim
// Holds offset and hysteresis codes and
// converts them into signed trim values
// ==============================

module comp_cal_trim (
    input  logic                       clk_i,
    input  logic                       reset_n_i,
    input  logic                       cal_enable_i,  // Trims active
    input  logic                       cal_valid_i,   // Load strobe
    input  comp_latch_pkg::cal_code_t  cal_offset_i,
    input  comp_latch_pkg::hyst_code_t hysteresis_i,
    output comp_volt_pkg::vdiff_t      offset_trim_o, // LSB per code step
    output comp_volt_pkg::vdiff_t      hyst_trim_o    // HYST_STEP_CODE per step
);

    comp_latch_pkg::cal_code_t  offset_code_q;
    comp_latch_pkg::hyst_code_t hyst_code_q;

    // ==============================
    // Code registers
    // ==============================

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            offset_code_q <= '0;
            hyst_code_q   <= '0;
        end else if (cal_valid_i) begin
            offset_code_q <= cal_offset_i;
            hyst_code_q   <= hysteresis_i;
        end
    end

    // ==============================
    // Trim conversion
    // ==============================

    // Follows live cal_enable_i, no extra register
    always_comb begin
        if (cal_enable_i) begin
            // Offset centred on mid code, -128 .. +127
            offset_trim_o = comp_volt_pkg::vdiff_t'(offset_code_q)
                          - comp_volt_pkg::vdiff_t'(comp_latch_pkg::CAL_MID_CODE);
            // Hysteresis is unsigned, 0 .. 120
            hyst_trim_o   = comp_volt_pkg::vdiff_t'(hyst_code_q)
                          * comp_volt_pkg::vdiff_t'(comp_latch_pkg::HYST_STEP_CODE);
        end else begin
            offset_trim_o = '0;
            hyst_trim_o   = '0;  // Calibration bypassed
        end
    end

endmodule : comp_cal_trim

// ==== comp_preamp.sv ====
// ==============================
// Comparator preamplifier
// Offset, gain of 32, offset trim and rail clamping
// Registered differential output
// ==============================

module comp_preamp (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  comp_volt_pkg::volt_t  vin_p_i,
    input  comp_volt_pkg::volt_t  vin_n_i,
    input  comp_volt_pkg::vdiff_t offset_trim_i,
    output comp_volt_pkg::vdiff_t preamp_diff_o  // Clamped p minus n
);

    // 25 bits covers full input swing times 32
    logic signed [24:0] vin_diff;
    logic signed [24:0] vin_mean;  // Input common mode
    logic signed [24:0] amp_in;
    logic signed [24:0] amp_out;
    logic signed [24:0] lvl_p;
    logic signed [24:0] lvl_n;
    logic signed [24:0] clamp_p;
    logic signed [24:0] clamp_n;

    // ==============================
    // Gain stage
    // ==============================

    always_comb begin
        vin_diff = $signed({9'b0, vin_p_i}) - $signed({9'b0, vin_n_i});
        vin_mean = ($signed({9'b0, vin_p_i}) + $signed({9'b0, vin_n_i})) >>> 1;

        // Built-in offset adds, calibration trim cancels it
        amp_in  = vin_diff + $signed({9'b0, comp_volt_pkg::PREAMP_OFFSET_CODE})
                - $signed({{7{offset_trim_i[17]}}, offset_trim_i});
        amp_out = amp_in <<< comp_volt_pkg::PREAMP_GAIN_SHIFT;

        // Split around input mean, exact since amp_out is even
        lvl_p = vin_mean + (amp_out >>> 1);
        lvl_n = vin_mean - (amp_out >>> 1);

        // Output swing limit
        if (lvl_p > $signed({9'b0, comp_volt_pkg::RAIL_HI_CODE})) begin
            clamp_p = $signed({9'b0, comp_volt_pkg::RAIL_HI_CODE});
        end else if (lvl_p < $signed({9'b0, comp_volt_pkg::RAIL_LO_CODE})) begin
            clamp_p = $signed({9'b0, comp_volt_pkg::RAIL_LO_CODE});
        end else begin
            clamp_p = lvl_p;
        end

        if (lvl_n > $signed({9'b0, comp_volt_pkg::RAIL_HI_CODE})) begin
            clamp_n = $signed({9'b0, comp_volt_pkg::RAIL_HI_CODE});
        end else if (lvl_n < $signed({9'b0, comp_volt_pkg::RAIL_LO_CODE})) begin
            clamp_n = $signed({9'b0, comp_volt_pkg::RAIL_LO_CODE});
        end else begin
            clamp_n = lvl_n;
        end
    end

    // One cycle from input sample to output
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            preamp_diff_o <= '0;
        end else begin
            preamp_diff_o <= comp_volt_pkg::vdiff_t'(clamp_p - clamp_n); // Within rails
        end
    end

endmodule : comp_preamp

// ==== comp_regen_latch.sv ====
// ==============================
// Comparator regenerative latch
// Integrates the latch input during the latch phase
// Threshold decision, valid and metastable flags
// ==============================

module comp_regen_latch (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  latch_phase_d_i,
    input  logic                  reset_phase_d_i,
    input  comp_volt_pkg::vdiff_t preamp_diff_i,
    input  comp_volt_pkg::vdiff_t hyst_trim_i,
    output logic                  comp_out_o,       // Decision, held while undecided
    output logic                  comp_out_valid_o, // Integrator beyond threshold
    output logic                  metastable_o      // Latch still inside the dead band
);

    comp_latch_pkg::regen_t regen_q;    // Integrator state
    comp_latch_pkg::regen_t latch_in;   // Preamp plus hysteresis
    comp_latch_pkg::regen_t regen_step;
    comp_latch_pkg::regen_t regen_next;
    logic signed [20:0]     regen_sum;  // One extra bit for saturation

    // ==============================
    // Integration
    // ==============================

    always_comb begin
        // Hysteresis counts on both latch inputs, so twice
        latch_in   = comp_latch_pkg::regen_t'(preamp_diff_i)
                   + (comp_latch_pkg::regen_t'(hyst_trim_i) <<< 1);
        regen_step = latch_in >>> comp_latch_pkg::REGEN_SHIFT;
        regen_sum  = 21'(regen_q) + 21'(regen_step);

        if (regen_sum > comp_latch_pkg::REGEN_MAX) begin
            regen_next = comp_latch_pkg::REGEN_MAX;
        end else if (regen_sum < comp_latch_pkg::REGEN_MIN) begin
            regen_next = comp_latch_pkg::REGEN_MIN;
        end else begin
            regen_next = comp_latch_pkg::regen_t'(regen_sum);
        end
    end

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            regen_q <= '0;
        end else if (reset_phase_d_i) begin
            regen_q <= '0;           // Back to common mode
        end else if (latch_phase_d_i) begin
            regen_q <= regen_next;
        end
    end

    // ==============================
    // Decision
    // ==============================

    // Uses integrator value before this cycle's update
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            comp_out_o       <= 1'b0;
            comp_out_valid_o <= 1'b0;
            metastable_o     <= 1'b0;
        end else if (latch_phase_d_i) begin
            if (regen_q > comp_latch_pkg::REGEN_THRESHOLD) begin
                comp_out_o       <= 1'b1;
                comp_out_valid_o <= 1'b1;
                metastable_o     <= 1'b0;
            end else if (regen_q < -comp_latch_pkg::REGEN_THRESHOLD) begin
                comp_out_o       <= 1'b0;
                comp_out_valid_o <= 1'b1;
                metastable_o     <= 1'b0;
            end else begin
                // Undecided, keep last output
                comp_out_valid_o <= 1'b0;
                metastable_o     <= 1'b1;
            end
        end else begin
            comp_out_valid_o <= 1'b0;  // Flags only live in latch phase
            metastable_o     <= 1'b0;
        end
    end

endmodule : comp_regen_latch

// ==== comparator_top.sv ====
// ==============================
// Latched comparator top level
// Phase control, calibration trim,
// preamp and regenerative latch
// ==============================

module comparator_top (
    input  logic                       clk_i,
    input  logic                       reset_n_i,
    input  logic                       enable_i,
    input  logic                       latch_enable_i,   // Latch phase request
    input  logic                       reset_latch_i,    // Reset phase request
    input  comp_latch_pkg::hyst_code_t hysteresis_i,
    input  logic                       cal_enable_i,
    input  comp_latch_pkg::cal_code_t  cal_offset_i,
    input  logic                       cal_valid_i,
    input  comp_volt_pkg::volt_t       vin_p_i,
    input  comp_volt_pkg::volt_t       vin_n_i,
    output logic                       comp_out_o,
    output logic                       comp_out_valid_o,
    output logic                       metastable_o,
    output logic                       ready_o
);

    logic                  latch_phase_d;
    logic                  reset_phase_d;
    comp_volt_pkg::vdiff_t offset_trim;  // To preamp
    comp_volt_pkg::vdiff_t hyst_trim;    // To latch
    comp_volt_pkg::vdiff_t preamp_diff;

    comp_phase_ctrl comp_phase_ctrl_inst (
        .clk_i           (clk_i),
        .reset_n_i       (reset_n_i),
        .enable_i        (enable_i),
        .latch_enable_i  (latch_enable_i),
        .reset_latch_i   (reset_latch_i),
        .latch_phase_d_o (latch_phase_d),
        .reset_phase_d_o (reset_phase_d),
        .ready_o         (ready_o)
    );

    comp_cal_trim comp_cal_trim_inst (
        .clk_i         (clk_i),
        .reset_n_i     (reset_n_i),
        .cal_enable_i  (cal_enable_i),
        .cal_valid_i   (cal_valid_i),
        .cal_offset_i  (cal_offset_i),
        .hysteresis_i  (hysteresis_i),
        .offset_trim_o (offset_trim),
        .hyst_trim_o   (hyst_trim)
    );

    comp_preamp comp_preamp_inst (
        .clk_i         (clk_i),
        .reset_n_i     (reset_n_i),
        .vin_p_i       (vin_p_i),
        .vin_n_i       (vin_n_i),
        .offset_trim_i (offset_trim),
        .preamp_diff_o (preamp_diff)
    );

    comp_regen_latch comp_regen_latch_inst (
        .clk_i            (clk_i),
        .reset_n_i        (reset_n_i),
        .latch_phase_d_i  (latch_phase_d),
        .reset_phase_d_i  (reset_phase_d),
        .preamp_diff_i    (preamp_diff),
        .hyst_trim_i      (hyst_trim),
        .comp_out_o       (comp_out_o),
        .comp_out_valid_o (comp_out_valid_o),
        .metastable_o     (metastable_o)
    );

endmodule : comparator_top

// ==== tb_comparator.sv ====
// ==============================
// Latched comparator testbench
// Reads test vectors, runs latch/reset phases on
// the DUT and checks decision, valid and flags
// ==============================

module tb_comparator;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD     = 10;
    localparam int    RESET_CYCLES   = 10;
    localparam int    DECIDE_TIMEOUT = 300; // Also the metastable window
    localparam int    SHORT_TIMEOUT  = 10;
    localparam string VECTOR_FILE    = "comparator_vectors.txt";

    logic                       clk;
    logic                       reset_n;
    logic                       enable;
    logic                       latch_enable;
    logic                       reset_latch;
    comp_latch_pkg::hyst_code_t hysteresis;
    logic                       cal_enable;
    comp_latch_pkg::cal_code_t  cal_offset;
    logic                       cal_valid;
    comp_volt_pkg::volt_t       vin_p;
    comp_volt_pkg::volt_t       vin_n;
    logic                       comp_out;
    logic                       comp_out_valid;
    logic                       metastable;
    logic                       ready;

    int error_count = 0;
    int test_count  = 0;
    int pass_count  = 0;

    comparator_top comparator_top_inst (
        .clk_i            (clk),
        .reset_n_i        (reset_n),
        .enable_i         (enable),
        .latch_enable_i   (latch_enable),
        .reset_latch_i    (reset_latch),
        .hysteresis_i     (hysteresis),
        .cal_enable_i     (cal_enable),
        .cal_offset_i     (cal_offset),
        .cal_valid_i      (cal_valid),
        .vin_p_i          (vin_p),
        .vin_n_i          (vin_n),
        .comp_out_o       (comp_out),
        .comp_out_valid_o (comp_out_valid),
        .metastable_o     (metastable),
        .ready_o          (ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Compare and report helpers
    // ==============================

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what, input int limit);
        $display("At %0d ns the wait for %s gave up after %0d cycles", $time, what, limit);
        error_count++;
    endtask

    // ==============================
    // Bounded waits, sampled at negedge
    // ==============================

    task automatic wait_signal(input string what, input int limit, input bit level,
                               output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (what == "comp_out_valid_o") seen = (comp_out_valid === level);
            else                            seen = (ready === level);
        end
        if (!seen) report_timeout({what, level ? " high" : " low"}, limit);
    endtask

    // Metastable case, never decides
    task automatic watch_window(output int valid_cycles, output int meta_drops);
        logic meta_seen;
        int   n;
        valid_cycles = 0;
        meta_drops   = 0;
        meta_seen    = 1'b0;
        for (n = 0; n < DECIDE_TIMEOUT; n++) begin
            @(negedge clk);
            if (comp_out_valid) valid_cycles++;
            if (metastable) meta_seen = 1'b1;
            else if (meta_seen) meta_drops++;   // Flag fell inside the latch phase
        end
    endtask

    // ==============================
    // One vector: reset phase, cal load, latch phase
    // ==============================

    task automatic run_vector(input comp_volt_pkg::volt_t p, input comp_volt_pkg::volt_t n,
                              input logic cal_en, input comp_latch_pkg::cal_code_t ofs,
                              input comp_latch_pkg::hyst_code_t hy, input logic exp_out,
                              input logic exp_valid, input string name);
        int cycles;
        int valid_cycles;
        int meta_drops;
        int errors_before;
        errors_before = error_count;
        cycles        = 0;

        @(posedge clk);
        latch_enable <= 1'b0;
        reset_latch  <= 1'b1;     // Clears the integrator
        vin_p        <= p;
        vin_n        <= n;
        cal_enable   <= cal_en;
        @(posedge clk);
        reset_latch  <= 1'b0;
        cal_valid    <= 1'b1;
        cal_offset   <= ofs;
        hysteresis   <= hy;
        @(posedge clk);
        cal_valid    <= 1'b0;

        // Old decision must go away with the latch phase
        wait_signal("comp_out_valid_o", SHORT_TIMEOUT, 1'b0, cycles);

        @(posedge clk);
        latch_enable <= 1'b1;
        if (exp_valid) begin
            wait_signal("comp_out_valid_o", DECIDE_TIMEOUT, 1'b1, cycles);
            if (comp_out_valid) begin
                check_bit("comp_out_o", exp_out, comp_out);
                check_bit("metastable_o", 1'b0, metastable);
                check_bit("ready_o", 1'b0, ready);  // Busy in latch phase
            end
        end else begin
            watch_window(valid_cycles, meta_drops);
            cycles = DECIDE_TIMEOUT;
            check_count("comp_out_valid_o high cycles", 0, valid_cycles);
            check_count("metastable_o drops", 0, meta_drops);
            check_bit("metastable_o", 1'b1, metastable);
            check_bit("comp_out_o", exp_out, comp_out);  // Held from last decision
        end

        test_count++;
        if (error_count == errors_before) pass_count++;
        $display("%0d ns  %s  %s  %0d cycles", $time, name,
                 (error_count == errors_before) ? "pass" : "fail", cycles);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int    fd;
        int    cycles;
        int    f_p, f_n, f_cal, f_ofs, f_hyst, f_out, f_valid;
        string line;
        string name;

        reset_n      = 1'b0;
        enable       = 1'b0;
        latch_enable = 1'b0;
        reset_latch  = 1'b0;
        hysteresis   = '0;
        cal_enable   = 1'b0;
        cal_offset   = '0;
        cal_valid    = 1'b0;
        vin_p        = comp_volt_pkg::VCM_CODE;
        vin_n        = comp_volt_pkg::VCM_CODE;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        repeat (2) @(negedge clk);
        check_bit("comp_out_o", 1'b0, comp_out);
        check_bit("comp_out_valid_o", 1'b0, comp_out_valid);
        check_bit("metastable_o", 1'b0, metastable);
        check_bit("ready_o", 1'b0, ready);   // Not enabled yet

        @(posedge clk);
        enable <= 1'b1;
        wait_signal("ready_o", SHORT_TIMEOUT, 1'b1, cycles);
        $display("%0d ns  after_reset  %s", $time, (error_count == 0) ? "pass" : "fail");

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("The vector file %s could not be opened", VECTOR_FILE);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Comment and blank lines do not scan
                if ($sscanf(line, "%d %d %d %d %d %d %d %s", f_p, f_n, f_cal, f_ofs,
                            f_hyst, f_out, f_valid, name) == 8) begin
                    run_vector(comp_volt_pkg::volt_t'(f_p), comp_volt_pkg::volt_t'(f_n),
                               f_cal[0], comp_latch_pkg::cal_code_t'(f_ofs),
                               comp_latch_pkg::hyst_code_t'(f_hyst), f_out[0],
                               f_valid[0], name);
                end
            end
            $fclose(fd);
        end
        if (test_count == 0) begin
            $display("No test vectors were found in %s", VECTOR_FILE);
            error_count++;
        end

        $display("%0d tests, %0d passed, %0d errors", test_count, pass_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_comparator

// ==== comparator_vectors.txt ====
# vin_p vin_n cal_enable cal_offset hysteresis exp_comp_out exp_valid name
# Decimal codes, 1 LSB = 78.125 uV; exp_valid 0 marks a metastable test
#
# Plain decisions, calibration off
17920 17720 0 128 0  1 1 plain_pos
17720 17920 0 128 0  0 1 plain_neg
19920 17920 0 128 0  1 1 clamp_pos
#
# Built-in offset wins at -6 LSB, trim of +20 flips it
17917 17923 0 128 0  1 1 offset_off
17917 17923 1 148 0  0 1 offset_trim
#
# Hysteresis at -14 LSB, 16 LSB per code on the latch input
17913 17927 1 128 0  0 1 hyst_zero
17913 17927 1 128 15 1 1 hyst_max
#
# -10 LSB cancels the offset, output holds the last decision
17915 17925 0 128 0  1 0 metastable
#
# Opposite inputs back to back, integrator must start from zero
17920 17720 0 128 0  1 1 after_meta_pos
17720 17920 0 128 0  0 1 reset_phase_neg

// ==== sim.f ====
comp_volt_pkg.sv
comp_latch_pkg.sv
comp_phase_ctrl.sv
comp_cal_trim.sv
comp_preamp.sv
comp_regen_latch.sv
comparator_top.sv
tb_comparator.sv

// ==== Makefile ====
# Verilator simulation of the latched comparator

VERILATOR ?= verilator
TOP       ?= tb_comparator
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary -Wno-fatal --timescale $(TIMESCALE)
FAIL_MSG  ?= Test FAILED

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, output in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(wildcard *.sv) comparator_vectors.txt
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
